//--- rv_core.f
src/rv_core_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core_top.sv
tests/rv_core_tb.sv

//--- src/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	// ##########################################################################
	// Widths.
	// ##########################################################################

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic tag_t;

	localparam int MUL_STEPS = 32;
	localparam int MUL_CNT_W = $clog2(MUL_STEPS);

	// ##########################################################################
	// Instruction encodings.
	// ##########################################################################

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {SEL_ZERO, SEL_RS1, SEL_RS2, SEL_PC, SEL_IMM} operand_sel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} branch_cond_e;

	typedef enum logic [1:0] {EX_IDLE, EX_MULTIPLY, EX_RETIRE} exec_state_e;

	// ##########################################################################
	// Stage payloads.
	// ##########################################################################

	typedef struct packed {
		word_t pc;
		word_t instr;
	} instr_in_t;

	typedef struct packed {
		tag_t tag;
		word_t pc;
		word_t instr;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} fetch_data_t;

	typedef struct packed {
		tag_t tag;
		word_t pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t imm;
		alu_op_e alu_op;
		operand_sel_e op1_sel;
		operand_sel_e op2_sel;
		branch_cond_e branch;
		logic jump;
		logic jump_reg;
		logic write_en;
	} decode_data_t;

	typedef struct packed {
		word_t pc;
		reg_idx_t rd;
		word_t value;
		logic write_en;
		logic taken;
		word_t target;
	} retire_t;

endpackage

`default_nettype wire

//--- src/rv_core_top.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_top (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire rv_core_pkg::instr_in_t i_instr,
	input wire logic i_instr_valid,
	output logic o_instr_ready,
	output rv_core_pkg::retire_t o_result,
	output logic o_result_valid,
	output logic o_fault
);

	import rv_core_pkg::*;

	fetch_data_t fetch_data;
	decode_data_t decode_data;
	tag_t decode_taken_tag;
	tag_t exec_taken_tag;
	reg_idx_t rs1_addr;
	reg_idx_t rs2_addr;
	reg_idx_t wr_rd;
	word_t rs1_data;
	word_t rs2_data;
	word_t wr_data;
	logic wr_en;

	rv_fetch fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr(i_instr),
		.i_instr_valid(i_instr_valid),
		.i_taken_tag(decode_taken_tag),
		.o_instr_ready(o_instr_ready),
		.o_data(fetch_data)
	);

	rv_decode decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(fetch_data),
		.i_taken_tag(exec_taken_tag),
		.o_taken_tag(decode_taken_tag),
		.o_data(decode_data),
		.o_fault(o_fault)
	);

	rv_execute execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(decode_data),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_taken_tag(exec_taken_tag),
		.o_rs1(rs1_addr),
		.o_rs2(rs2_addr),
		.o_we(wr_en),
		.o_rd(wr_rd),
		.o_wdata(wr_data),
		.o_result(o_result),
		.o_result_valid(o_result_valid)
	);

	rv_regfile regfile (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1(rs1_addr),
		.i_rs2(rs2_addr),
		.i_we(wr_en),
		.i_rd(wr_rd),
		.i_wdata(wr_data),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

endmodule

`default_nettype wire

//--- src/rv_decode.sv
`default_nettype none
`timescale 1ns/1ps

module rv_decode (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire rv_core_pkg::fetch_data_t i_data,
	input wire rv_core_pkg::tag_t i_taken_tag,
	output rv_core_pkg::tag_t o_taken_tag,
	output rv_core_pkg::decode_data_t o_data,
	output logic o_fault
);

	import rv_core_pkg::*;

	word_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	word_t imm;
	alu_op_e alu_op;
	operand_sel_e op1_sel;
	operand_sel_e op2_sel;
	branch_cond_e branch;
	logic jump;
	logic jump_reg;
	logic write_en;
	logic legal;
	logic consume;

	assign instr = i_data.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// ##########################################################################
	// Instruction classification.
	// ##########################################################################

	always_comb begin
		imm = imm_i;
		alu_op = ALU_ADD;
		op1_sel = SEL_RS1;
		op2_sel = SEL_IMM;
		branch = BR_NONE;
		jump = 1'b0;
		jump_reg = 1'b0;
		write_en = 1'b1;
		legal = 1'b0;
		case (opcode)
			OPC_OP: begin
				op2_sel = SEL_RS2;
				if (funct7 == FUNCT7_BASE) begin
					legal = 1'b1;
					case (funct3)
						3'd0: alu_op = ALU_ADD;
						3'd1: alu_op = ALU_SLL;
						3'd2: alu_op = ALU_SLT;
						3'd3: alu_op = ALU_SLTU;
						3'd4: alu_op = ALU_XOR;
						3'd5: alu_op = ALU_SRL;
						3'd6: alu_op = ALU_OR;
						default: alu_op = ALU_AND;
					endcase
				end else if (funct7 == FUNCT7_ALT) begin
					legal = (funct3 == 3'd0) || (funct3 == 3'd5);
					alu_op = (funct3 == 3'd0) ? ALU_SUB : ALU_SRA;
				end else if (funct7 == FUNCT7_MULDIV) begin
					// Only MUL of the M extension is implemented.
					legal = (funct3 == 3'd0);
					alu_op = ALU_MUL;
				end
			end
			OPC_OP_IMM: begin
				legal = 1'b1;
				case (funct3)
					3'd0: alu_op = ALU_ADD;
					3'd1: begin
						alu_op = ALU_SLL;
						legal = (funct7 == FUNCT7_BASE);
					end
					3'd2: alu_op = ALU_SLT;
					3'd3: alu_op = ALU_SLTU;
					3'd4: alu_op = ALU_XOR;
					3'd5: begin
						alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
						legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
					end
					3'd6: alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			OPC_LUI: begin
				imm = imm_u;
				alu_op = ALU_PASS_B;
				op1_sel = SEL_ZERO;
				legal = 1'b1;
			end
			OPC_AUIPC: begin
				imm = imm_u;
				op1_sel = SEL_PC;
				legal = 1'b1;
			end
			OPC_JAL: begin
				imm = imm_j;
				op1_sel = SEL_PC;
				jump = 1'b1;
				legal = 1'b1;
			end
			OPC_JALR: begin
				jump = 1'b1;
				jump_reg = 1'b1;
				legal = (funct3 == 3'd0);
			end
			OPC_BRANCH: begin
				// The ALU forms pc + imm while the compare uses the register values.
				imm = imm_b;
				op1_sel = SEL_PC;
				write_en = 1'b0;
				legal = 1'b1;
				case (funct3)
					3'd0: branch = BR_EQ;
					3'd1: branch = BR_NE;
					3'd4: branch = BR_LT;
					3'd5: branch = BR_GE;
					3'd6: branch = BR_LTU;
					3'd7: branch = BR_GEU;
					default: legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	// A new fetch item is taken only after execute has taken our current one.
	assign consume = (i_data.tag != o_taken_tag) && (o_data.tag == i_taken_tag);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_taken_tag <= '0;
			o_data.tag <= '0;
			o_fault <= 1'b0;
		end else if (consume) begin
			o_taken_tag <= i_data.tag;
			if (legal) begin
				o_data.tag <= ~o_data.tag;
				o_data.pc <= i_data.pc;
				o_data.rs1 <= i_data.rs1;
				o_data.rs2 <= i_data.rs2;
				o_data.rd <= i_data.rd;
				o_data.imm <= imm;
				o_data.alu_op <= alu_op;
				o_data.op1_sel <= op1_sel;
				o_data.op2_sel <= op2_sel;
				o_data.branch <= branch;
				o_data.jump <= jump;
				o_data.jump_reg <= jump_reg;
				o_data.write_en <= write_en;
			end else begin
				o_fault <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/rv_execute.sv
`default_nettype none
`timescale 1ns/1ps

module rv_execute (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire rv_core_pkg::decode_data_t i_data,
	input wire rv_core_pkg::word_t i_rs1_data,
	input wire rv_core_pkg::word_t i_rs2_data,
	output rv_core_pkg::tag_t o_taken_tag,
	output rv_core_pkg::reg_idx_t o_rs1,
	output rv_core_pkg::reg_idx_t o_rs2,
	output logic o_we,
	output rv_core_pkg::reg_idx_t o_rd,
	output rv_core_pkg::word_t o_wdata,
	output rv_core_pkg::retire_t o_result,
	output logic o_result_valid
);

	import rv_core_pkg::*;

	exec_state_e state;
	logic [MUL_CNT_W-1:0] mul_count;
	word_t mul_acc;
	word_t mul_mcand;
	word_t mul_mplier;
	word_t mul_sum;
	retire_t pending;
	word_t op1;
	word_t op2;
	word_t alu_result;
	word_t target;
	logic cmp_true;
	logic take;

	function automatic word_t select_operand(operand_sel_e sel, word_t rs1, word_t rs2,
			word_t pc, word_t imm);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	assign o_rs1 = i_data.rs1;
	assign o_rs2 = i_data.rs2;
	assign op1 = select_operand(i_data.op1_sel, i_rs1_data, i_rs2_data, i_data.pc, i_data.imm);
	assign op2 = select_operand(i_data.op2_sel, i_rs1_data, i_rs2_data, i_data.pc, i_data.imm);

	always_comb begin
		case (i_data.alu_op)
			ALU_ADD: alu_result = op1 + op2;
			ALU_SUB: alu_result = op1 - op2;
			ALU_AND: alu_result = op1 & op2;
			ALU_OR: alu_result = op1 | op2;
			ALU_XOR: alu_result = op1 ^ op2;
			ALU_SLT: alu_result = {31'b0, $signed(op1) < $signed(op2)};
			ALU_SLTU: alu_result = {31'b0, op1 < op2};
			ALU_SLL: alu_result = op1 << op2[4:0];
			ALU_SRL: alu_result = op1 >> op2[4:0];
			ALU_SRA: alu_result = word_t'($signed(op1) >>> op2[4:0]);
			ALU_PASS_B: alu_result = op2;
			default: alu_result = '0;
		endcase
	end

	always_comb begin
		case (i_data.branch)
			BR_EQ: cmp_true = (i_rs1_data == i_rs2_data);
			BR_NE: cmp_true = (i_rs1_data != i_rs2_data);
			BR_LT: cmp_true = ($signed(i_rs1_data) < $signed(i_rs2_data));
			BR_GE: cmp_true = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			BR_LTU: cmp_true = (i_rs1_data < i_rs2_data);
			BR_GEU: cmp_true = (i_rs1_data >= i_rs2_data);
			default: cmp_true = 1'b0;
		endcase
	end

	// Jumps and branches both form their target in the ALU.
	assign target = i_data.jump_reg ? {alu_result[31:1], 1'b0} : alu_result;
	assign take = (state == EX_IDLE) && (i_data.tag != o_taken_tag);
	assign mul_sum = mul_acc + (mul_mplier[0] ? mul_mcand : '0);

	assign o_we = (state == EX_RETIRE) && pending.write_en;
	assign o_rd = pending.rd;
	assign o_wdata = pending.value;
	assign o_result = pending;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= EX_IDLE;
			o_taken_tag <= '0;
			o_result_valid <= 1'b0;
			mul_count <= '0;
		end else begin
			o_result_valid <= 1'b0;
			case (state)
				EX_IDLE: begin
					if (take) begin
						o_taken_tag <= i_data.tag;
						pending.pc <= i_data.pc;
						pending.rd <= i_data.rd;
						pending.write_en <= i_data.write_en;
						pending.taken <= i_data.jump || cmp_true;
						pending.target <= (i_data.jump || (i_data.branch != BR_NONE)) ? target : '0;
						pending.value <= i_data.jump ? i_data.pc + 32'd4 : alu_result;
						if (i_data.alu_op == ALU_MUL) begin
							mul_acc <= '0;
							mul_mcand <= op1;
							mul_mplier <= op2;
							mul_count <= '0;
							state <= EX_MULTIPLY;
						end else begin
							state <= EX_RETIRE;
						end
					end
				end
				EX_MULTIPLY: begin
					// One multiplier bit per cycle, low bit first.
					mul_acc <= mul_sum;
					mul_mcand <= mul_mcand << 1;
					mul_mplier <= mul_mplier >> 1;
					mul_count <= mul_count + 1'b1;
					if (mul_count == MUL_CNT_W'(MUL_STEPS - 1)) begin
						pending.value <= mul_sum;
						state <= EX_RETIRE;
					end
				end
				EX_RETIRE: begin
					o_result_valid <= 1'b1;
					state <= EX_IDLE;
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/rv_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module rv_fetch (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire rv_core_pkg::instr_in_t i_instr,
	input wire logic i_instr_valid,
	input wire rv_core_pkg::tag_t i_taken_tag,
	output logic o_instr_ready,
	output rv_core_pkg::fetch_data_t o_data
);

	import rv_core_pkg::*;

	word_t instr;
	logic accept;

	assign instr = i_instr.instr;

	// The slot is empty once decode has taken the tag we last handed out.
	assign o_instr_ready = (o_data.tag == i_taken_tag);
	assign accept = i_instr_valid && o_instr_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data.tag <= '0;
		end else if (accept) begin
			o_data.tag <= ~o_data.tag;
			o_data.pc <= i_instr.pc;
			o_data.instr <= instr;
			o_data.rs1 <= instr[19:15];
			o_data.rs2 <= instr[24:20];
			o_data.rd <= instr[11:7];
		end
	end

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module rv_regfile (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire rv_core_pkg::reg_idx_t i_rs1,
	input wire rv_core_pkg::reg_idx_t i_rs2,
	input wire logic i_we,
	input wire rv_core_pkg::reg_idx_t i_rd,
	input wire rv_core_pkg::word_t i_wdata,
	output rv_core_pkg::word_t o_rs1_data,
	output rv_core_pkg::word_t o_rs2_data
);

	import rv_core_pkg::*;

	word_t regs [32];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_rd != '0)) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// x0 always reads as zero.
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

//--- tests/rv_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;

	import rv_core_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RANDOM_COUNT = 200;
	localparam int STREAM_COUNT = 40;
	localparam int NUM_INSTR = 4 + RANDOM_COUNT + STREAM_COUNT + 12;
	localparam int LIMIT_CYCLES = NUM_INSTR * (MUL_STEPS + 8) + 500;

	logic i_clock;
	logic i_reset;
	instr_in_t i_instr;
	logic i_instr_valid;
	logic o_instr_ready;
	retire_t o_result;
	logic o_result_valid;
	logic o_fault;

	retire_t exp_q [$];
	word_t model_regs [32];
	word_t next_pc;
	string test_name;
	int cycle = 0;
	int accept_cycle;
	int retire_cycle;
	int longest_stall;
	int mismatch_count = 0;
	int other_count = 0;

	rv_core_top uut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr(i_instr),
		.i_instr_valid(i_instr_valid),
		.o_instr_ready(o_instr_ready),
		.o_result(o_result),
		.o_result_valid(o_result_valid),
		.o_fault(o_fault)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
	end

	always @(posedge i_clock) cycle <= cycle + 1;

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles.", LIMIT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	// ##########################################################################
	// Reference model.
	// ##########################################################################

	function automatic word_t alu_value(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Predicts the record of one instruction and applies its write to model_regs.
	function automatic retire_t ref_model(instr_in_t pkt);
		word_t ins;
		word_t a;
		word_t b;
		word_t imm_i;
		word_t imm_b;
		word_t imm_j;
		word_t imm_u;
		logic [2:0] f3;
		logic [6:0] f7;
		retire_t r;
		ins = pkt.instr;
		f3 = ins[14:12];
		f7 = ins[31:25];
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		r = '0;
		r.pc = pkt.pc;
		r.rd = ins[11:7];
		r.write_en = 1'b1;
		case (ins[6:0])
			OPC_OP: r.value = (f7 == FUNCT7_MULDIV) ? a * b : alu_value(f3, f7[5], a, b);
			OPC_OP_IMM: r.value = alu_value(f3, f7[5] && (f3 == 3'd5), a, imm_i);
			OPC_LUI: r.value = imm_u;
			OPC_AUIPC: r.value = pkt.pc + imm_u;
			OPC_JAL: begin
				r.value = pkt.pc + 32'd4;
				r.taken = 1'b1;
				r.target = pkt.pc + imm_j;
			end
			OPC_JALR: begin
				r.value = pkt.pc + 32'd4;
				r.taken = 1'b1;
				r.target = (a + imm_i) & ~32'd1;
			end
			default: begin
				r.write_en = 1'b0;
				r.target = pkt.pc + imm_b;
				case (f3)
					3'd0: r.taken = (a == b);
					3'd1: r.taken = (a != b);
					3'd4: r.taken = ($signed(a) < $signed(b));
					3'd5: r.taken = ($signed(a) >= $signed(b));
					3'd6: r.taken = (a < b);
					default: r.taken = (a >= b);
				endcase
			end
		endcase
		if (r.write_en && (r.rd != '0)) model_regs[r.rd] = r.value;
		return r;
	endfunction

	// The kind picks OP, OP-IMM, LUI, AUIPC, JAL, JALR, branch or MUL, counting from 0.
	function automatic word_t random_instr(int kind);
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		logic [19:0] upper;
		int r;
		// A small register set makes dependencies and x0 accesses frequent.
		rd = 5'($urandom_range(0, 7));
		rs1 = 5'($urandom_range(0, 7));
		rs2 = 5'($urandom_range(0, 7));
		f3 = 3'($urandom_range(0, 7));
		imm = 12'($urandom);
		upper = 20'($urandom);
		case (kind)
			0: begin
				f7 = FUNCT7_BASE;
				if (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(0, 1) == 1)) f7 = FUNCT7_ALT;
				return {f7, rs2, rs1, f3, rd, OPC_OP};
			end
			1: begin
				if (f3 == 3'd1) imm[11:5] = FUNCT7_BASE;
				if (f3 == 3'd5) imm[11:5] = ($urandom_range(0, 1) == 1) ? FUNCT7_ALT : FUNCT7_BASE;
				return {imm, rs1, f3, rd, OPC_OP_IMM};
			end
			2: return {upper, rd, OPC_LUI};
			3: return {upper, rd, OPC_AUIPC};
			4: return {upper, rd, OPC_JAL};
			5: return {imm, rs1, 3'd0, rd, OPC_JALR};
			6: begin
				r = $urandom_range(0, 5);
				f3 = (r < 2) ? 3'(r) : 3'(r + 2);
				return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_BRANCH};
			end
			default: return {FUNCT7_MULDIV, rs2, rs1, 3'd0, rd, OPC_OP};
		endcase
	endfunction

	// ##########################################################################
	// Checks and drivers.
	// ##########################################################################

	function automatic string show_retire(retire_t r);
		return $sformatf("pc=%h rd=%0d value=%h we=%b taken=%b target=%h",
			r.pc, r.rd, r.value, r.write_en, r.taken, r.target);
	endfunction

	task automatic check_retire(string name, retire_t exp, retire_t act);
		retire_t seen;
		seen = act;
		// A branch writes nothing, so its value field is not compared.
		if (!exp.write_en) seen.value = exp.value;
		if (seen !== exp) begin
			mismatch_count++;
			$display("Mismatch in %s: expected %s, actual %s", name, show_retire(exp),
				show_retire(act));
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			mismatch_count++;
			$display("Mismatch in %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_latency(string name, int exp, int act);
		if (act != exp) begin
			mismatch_count++;
			$display("Mismatch in %s: expected %0d cycles, actual %0d cycles", name, exp, act);
		end
	endtask

	task automatic send_instr(word_t instr, int gap, logic legal);
		instr_in_t pkt;
		int waits;
		pkt.pc = next_pc;
		pkt.instr = instr;
		next_pc = next_pc + 32'd4;
		waits = 0;
		repeat (gap) begin
			@(negedge i_clock);
			i_instr_valid = 1'b0;
		end
		@(negedge i_clock);
		i_instr_valid = 1'b1;
		i_instr = pkt;
		while (!o_instr_ready) begin
			waits++;
			@(negedge i_clock);
		end
		if (waits > longest_stall) longest_stall = waits;
		// Ready is high here, so the next rising edge takes the packet.
		accept_cycle = cycle + 1;
		if (legal) exp_q.push_back(ref_model(pkt));
	endtask

	task automatic drain;
		@(negedge i_clock);
		i_instr_valid = 1'b0;
		while (exp_q.size() != 0) @(negedge i_clock);
		repeat (4) @(negedge i_clock);
	endtask

	task automatic apply_reset;
		i_reset = 1'b1;
		i_instr_valid = 1'b0;
		repeat (2) @(negedge i_clock);
		i_reset = 1'b0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		exp_q.delete();
	endtask

	// Every record is matched against the oldest instruction still outstanding.
	initial begin
		forever begin
			@(negedge i_clock);
			if (!i_reset && o_result_valid) begin
				retire_cycle = cycle;
				if (exp_q.size() == 0) begin
					other_count++;
					$display("Error in %s: a record retired with no instruction outstanding.",
						test_name);
				end else begin
					check_retire(test_name, exp_q.pop_front(), o_result);
				end
			end
		end
	end

	// ##########################################################################
	// Test sequence.
	// ##########################################################################

	initial begin
		void'($urandom(26365));
		i_reset = 1'b1;
		i_instr_valid = 1'b0;
		i_instr = '0;
		next_pc = 32'h0000_1000;
		longest_stall = 0;
		test_name = "reset";
		apply_reset();
		check_flag("reset ready", 1'b1, o_instr_ready);
		check_flag("reset valid", 1'b0, o_result_valid);
		check_flag("reset fault", 1'b0, o_fault);

		test_name = "latency";
		for (int k = 0; k < 4; k++) begin
			send_instr(random_instr((k == 3) ? 6 : ((k == 2) ? 4 : k + 1)), 0, 1'b1);
			drain();
			check_latency(test_name, 3, retire_cycle - accept_cycle);
		end

		test_name = "random program";
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			send_instr(random_instr($urandom_range(0, 7)), $urandom_range(0, 3), 1'b1);
		end
		drain();
		check_flag("random program fault", 1'b0, o_fault);

		// Valid stays high, and every fifth instruction is a MUL.
		test_name = "back-to-back";
		longest_stall = 0;
		for (int n = 0; n < STREAM_COUNT; n++) begin
			send_instr(random_instr((n % 5 == 2) ? 7 : $urandom_range(0, 6)), 0, 1'b1);
		end
		drain();
		if (longest_stall < MUL_STEPS / 2) begin
			other_count++;
			$display("Error in %s: ready did not stay low while a multiply was running.",
				test_name);
		end
		check_flag("back-to-back fault", 1'b0, o_fault);

		test_name = "illegal";
		send_instr(random_instr(1), 0, 1'b1);
		send_instr({25'($urandom_range(0, 32'h1ff_ffff)), 7'b0000011}, 0, 1'b0);
		send_instr(random_instr(0), 0, 1'b1);
		send_instr({FUNCT7_MULDIV, 5'd2, 5'd1, 3'd1, 5'd3, OPC_OP}, 0, 1'b0);
		send_instr(random_instr(7), 0, 1'b1);
		drain();
		check_flag("illegal fault", 1'b1, o_fault);
		for (int n = 0; n < 3; n++) begin
			send_instr(random_instr($urandom_range(0, 7)), $urandom_range(0, 2), 1'b1);
		end
		drain();
		check_flag("sticky fault", 1'b1, o_fault);

		test_name = "after reset";
		apply_reset();
		check_flag("fault cleared", 1'b0, o_fault);
		check_flag("ready after reset", 1'b1, o_instr_ready);
		for (int n = 0; n < 4; n++) begin
			send_instr(random_instr($urandom_range(0, 7)), 1, 1'b1);
		end
		drain();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if ((mismatch_count == 0) && (other_count == 0)) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
